// File: verilog/exu_pkg.sv
package exu_pkg;

	localparam int data_width = 32;

	// Shift amount comes from the low bits of operand b
	localparam int shamt_width = $clog2(data_width);

	// ALU operation codes
	localparam int alu_opt_width = 4;

	localparam logic [alu_opt_width-1:0] alu_add  = 4'd0;
	localparam logic [alu_opt_width-1:0] alu_sub  = 4'd1;
	localparam logic [alu_opt_width-1:0] alu_sll  = 4'd2;
	localparam logic [alu_opt_width-1:0] alu_slt  = 4'd3;
	localparam logic [alu_opt_width-1:0] alu_sltu = 4'd4;
	localparam logic [alu_opt_width-1:0] alu_xor  = 4'd5;
	localparam logic [alu_opt_width-1:0] alu_srl  = 4'd6;
	localparam logic [alu_opt_width-1:0] alu_sra  = 4'd7;
	localparam logic [alu_opt_width-1:0] alu_or   = 4'd8;
	localparam logic [alu_opt_width-1:0] alu_and  = 4'd9;

	// Operand pair selection
	localparam int src_sel_width = 2;

	localparam logic [src_sel_width-1:0] src_sel_rs1_rs2 = 2'd0;
	localparam logic [src_sel_width-1:0] src_sel_rs1_imm = 2'd1;
	localparam logic [src_sel_width-1:0] src_sel_pc_4    = 2'd2;
	localparam logic [src_sel_width-1:0] src_sel_pc_imm  = 2'd3;

	// Iteration count of the multiply and divide loops
	localparam int iter_steps     = 32;
	localparam int iter_cnt_width = $clog2(iter_steps);

	// Counter value of the last loop cycle
	localparam logic [iter_cnt_width-1:0] iter_last = iter_cnt_width'(iter_steps - 1);

endpackage

// File: verilog/exu_alu.sv
module exu_alu (
	input  logic [exu_pkg::alu_opt_width-1:0] alu_opt,
	input  logic [exu_pkg::data_width-1:0]    a,
	input  logic [exu_pkg::data_width-1:0]    b,
	output logic [exu_pkg::data_width-1:0]    result
);

	logic [exu_pkg::shamt_width-1:0] shamt;
	logic                            lt_signed;
	logic                            lt_unsigned;

	assign shamt       = b[exu_pkg::shamt_width-1:0];
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_opt)
			exu_pkg::alu_add: begin
				result = a + b;
			end
			exu_pkg::alu_sub: begin
				result = a - b;
			end
			exu_pkg::alu_sll: begin
				result = a << shamt;
			end
			// Compares leave their answer in bit 0
			exu_pkg::alu_slt: begin
				result = {{(exu_pkg::data_width-1){1'b0}}, lt_signed};
			end
			exu_pkg::alu_sltu: begin
				result = {{(exu_pkg::data_width-1){1'b0}}, lt_unsigned};
			end
			exu_pkg::alu_xor: begin
				result = a ^ b;
			end
			exu_pkg::alu_srl: begin
				result = a >> shamt;
			end
			exu_pkg::alu_sra: begin
				result = $signed(a) >>> shamt;
			end
			exu_pkg::alu_or: begin
				result = a | b;
			end
			exu_pkg::alu_and: begin
				result = a & b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: verilog/exu_mul.sv
module exu_mul (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [1:0]                     mul_signed,
	input  logic [exu_pkg::data_width-1:0] multiplicand,
	input  logic [exu_pkg::data_width-1:0] multiplier,
	input  logic                           mul_valid,
	output logic                           mul_ready,
	output logic                           out_valid,
	output logic [exu_pkg::data_width-1:0] result_hi,
	output logic [exu_pkg::data_width-1:0] result_lo
);

	logic                               busy;
	logic                               fin;
	logic [exu_pkg::iter_cnt_width-1:0] count;
	logic                               accept;
	logic                               a_neg;
	logic                               b_neg;
	logic [exu_pkg::data_width-1:0]     a_mag;
	logic [exu_pkg::data_width-1:0]     b_mag;
	logic                               prod_neg;
	logic [2*exu_pkg::data_width-1:0]   mcand;
	logic [exu_pkg::data_width-1:0]     mplier;
	logic [2*exu_pkg::data_width-1:0]   acc;
	logic [2*exu_pkg::data_width-1:0]   product;

	assign accept    = mul_valid & mul_ready;
	assign mul_ready = ~busy & ~fin;

	// Work on magnitudes and apply the sign at the end
	assign a_neg = mul_signed[1] & multiplicand[exu_pkg::data_width-1];
	assign b_neg = mul_signed[0] & multiplier[exu_pkg::data_width-1];
	assign a_mag = a_neg ? -multiplicand : multiplicand;
	assign b_mag = b_neg ? -multiplier : multiplier;

	assign product = prod_neg ? -acc : acc;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			fin       <= 1'b0;
			out_valid <= 1'b0;
			count     <= '0;
		end else begin
			fin       <= busy & (count == exu_pkg::iter_last);
			out_valid <= fin;
			if (accept) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == exu_pkg::iter_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// One partial product per cycle with multiplier bits taken lsb first
	always_ff @(posedge clock) begin
		if (accept) begin
			mcand    <= {{exu_pkg::data_width{1'b0}}, a_mag};
			mplier   <= b_mag;
			acc      <= '0;
			prod_neg <= a_neg ^ b_neg;
		end else if (busy) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
		if (fin) begin
			result_hi <= product[2*exu_pkg::data_width-1:exu_pkg::data_width];
			result_lo <= product[exu_pkg::data_width-1:0];
		end
	end

endmodule

// File: verilog/exu_div.sv
module exu_div (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           div_signed,
	input  logic [exu_pkg::data_width-1:0] dividend,
	input  logic [exu_pkg::data_width-1:0] divisor,
	input  logic                           div_valid,
	output logic                           div_ready,
	output logic                           out_valid,
	output logic [exu_pkg::data_width-1:0] quotient,
	output logic [exu_pkg::data_width-1:0] remainder
);

	logic                               busy;
	logic                               fin;
	logic [exu_pkg::iter_cnt_width-1:0] count;
	logic                               accept;
	logic                               a_neg;
	logic                               b_neg;
	logic [exu_pkg::data_width-1:0]     a_mag;
	logic [exu_pkg::data_width-1:0]     b_mag;
	logic [exu_pkg::data_width-1:0]     dvs;
	logic [exu_pkg::data_width-1:0]     quo;
	logic [exu_pkg::data_width-1:0]     rem;
	logic [exu_pkg::data_width:0]       rem_shift;
	logic [exu_pkg::data_width:0]       diff;
	logic                               q_neg;
	logic                               r_neg;
	logic                               div_zero;

	assign accept    = div_valid & div_ready;
	assign div_ready = ~busy & ~fin;

	assign a_neg = div_signed & dividend[exu_pkg::data_width-1];
	assign b_neg = div_signed & divisor[exu_pkg::data_width-1];
	assign a_mag = a_neg ? -dividend : dividend;
	assign b_mag = b_neg ? -divisor : divisor;

	// Bring down the next dividend bit and try the subtraction
	assign rem_shift = {rem, quo[exu_pkg::data_width-1]};
	assign diff      = rem_shift - {1'b0, dvs};

	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			fin       <= 1'b0;
			out_valid <= 1'b0;
			count     <= '0;
		end else begin
			fin       <= busy & (count == exu_pkg::iter_last);
			out_valid <= fin;
			if (accept) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == exu_pkg::iter_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			quo      <= a_mag;
			rem      <= '0;
			dvs      <= b_mag;
			q_neg    <= a_neg ^ b_neg;
			r_neg    <= a_neg;
			div_zero <= ~|divisor;
		end else if (busy) begin
			if (!diff[exu_pkg::data_width]) begin
				rem <= diff[exu_pkg::data_width-1:0];
				quo <= {quo[exu_pkg::data_width-2:0], 1'b1};
			end else begin
				rem <= rem_shift[exu_pkg::data_width-1:0];
				quo <= {quo[exu_pkg::data_width-2:0], 1'b0};
			end
		end
		// Magnitudes already give min and zero for min divided by minus one
		if (fin) begin
			quotient  <= div_zero ? '1 : (q_neg ? -quo : quo);
			// A zero divisor leaves the dividend magnitude in rem and the sign fix restores it
			remainder <= r_neg ? -rem : rem;
		end
	end

endmodule

// File: verilog/exu.sv
module exu (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [exu_pkg::data_width-1:0]    pc,
	input  logic [exu_pkg::data_width-1:0]    src1,
	input  logic [exu_pkg::data_width-1:0]    src2,
	input  logic [exu_pkg::data_width-1:0]    imm,
	input  logic                              branch,
	input  logic [exu_pkg::alu_opt_width-1:0] alu_opt,
	input  logic                              alu_mul,
	input  logic                              alu_div,
	input  logic [exu_pkg::src_sel_width-1:0] src_sel,
	input  logic [2:0]                        funct3,
	input  logic                              id_to_ex,
	input  logic                              ex_to_wb,
	output logic [exu_pkg::data_width-1:0]    exu_result,
	output logic                              zero_flag,
	output logic                              exu_finished,
	output logic                              exu_stall
);

	logic [exu_pkg::data_width-1:0] op_a;
	logic [exu_pkg::data_width-1:0] op_b;
	logic [exu_pkg::data_width-1:0] alu_out;
	logic                           branch_taken;
	logic                           alu_busy;
	logic                           alu_done;

	logic [1:0]                     mul_signed;
	logic [exu_pkg::data_width-1:0] mul_hi;
	logic [exu_pkg::data_width-1:0] mul_lo;
	logic [exu_pkg::data_width-1:0] mul_result;
	logic                           mul_valid;
	logic                           mul_ready;
	logic                           mul_out_valid;
	logic                           mul_doing;

	logic                           div_signed;
	logic [exu_pkg::data_width-1:0] quotient;
	logic [exu_pkg::data_width-1:0] remainder;
	logic [exu_pkg::data_width-1:0] div_result;
	logic                           div_valid;
	logic                           div_ready;
	logic                           div_out_valid;
	logic                           div_doing;

	assign zero_flag = ~|exu_result;

	always_comb begin
		case (src_sel)
			exu_pkg::src_sel_rs1_rs2: begin
				op_a = src1;
				op_b = src2;
			end
			exu_pkg::src_sel_rs1_imm: begin
				op_a = src1;
				op_b = imm;
			end
			exu_pkg::src_sel_pc_4: begin
				op_a = pc;
				op_b = {{(exu_pkg::data_width-3){1'b0}}, 3'd4};
			end
			default: begin
				op_a = pc;
				op_b = imm;
			end
		endcase
	end

	exu_alu u_alu (
		.alu_opt (alu_opt),
		.a       (op_a),
		.b       (op_b),
		.result  (alu_out)
	);

	// Equality comes from sub, ordered compares from slt or sltu
	always_comb begin
		case (funct3)
			3'b000:         branch_taken = ~|alu_out;
			3'b001:         branch_taken = |alu_out;
			3'b100, 3'b110: branch_taken = alu_out[0];
			3'b101, 3'b111: branch_taken = ~alu_out[0];
			default:        branch_taken = 1'b0;
		endcase
	end

	// mul, mulh, mulhsu, mulhu
	always_comb begin
		case (funct3[1:0])
			2'b00:   mul_signed = 2'b11;
			2'b01:   mul_signed = 2'b11;
			2'b10:   mul_signed = 2'b10;
			default: mul_signed = 2'b00;
		endcase
	end
	assign mul_result = (funct3[1:0] == 2'b00) ? mul_lo : mul_hi;

	// div, divu, rem, remu
	assign div_signed = ~funct3[0];
	assign div_result = funct3[1] ? remainder : quotient;

	// Start only on the dispatch strobe so held fields cannot restart a unit
	assign mul_valid = alu_mul & id_to_ex & ~mul_doing & ~mul_out_valid & ~exu_finished;
	assign div_valid = alu_div & id_to_ex & ~div_doing & ~div_out_valid & ~exu_finished;

	assign exu_stall = mul_valid | (mul_doing & ~mul_out_valid)
		| div_valid | (div_doing & ~div_out_valid);

	exu_mul u_mul (
		.clock        (clock),
		.reset        (reset),
		.mul_signed   (mul_signed),
		.multiplicand (op_a),
		.multiplier   (op_b),
		.mul_valid    (mul_valid),
		.mul_ready    (mul_ready),
		.out_valid    (mul_out_valid),
		.result_hi    (mul_hi),
		.result_lo    (mul_lo)
	);

	exu_div u_div (
		.clock      (clock),
		.reset      (reset),
		.div_signed (div_signed),
		.dividend   (op_a),
		.divisor    (op_b),
		.div_valid  (div_valid),
		.div_ready  (div_ready),
		.out_valid  (div_out_valid),
		.quotient   (quotient),
		.remainder  (remainder)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			alu_busy  <= 1'b0;
			mul_doing <= 1'b0;
			div_doing <= 1'b0;
		end else begin
			alu_busy <= id_to_ex;
			if (mul_out_valid) begin
				mul_doing <= 1'b0;
			end else if (mul_valid && mul_ready) begin
				mul_doing <= 1'b1;
			end
			if (div_out_valid) begin
				div_doing <= 1'b0;
			end else if (div_valid && div_ready) begin
				div_doing <= 1'b1;
			end
		end
	end

	// Single-cycle path finishes one edge after dispatch
	assign alu_done = alu_busy & ~alu_mul & ~alu_div;

	always_ff @(posedge clock) begin
		if (reset) begin
			exu_result   <= '0;
			exu_finished <= 1'b0;
		end else if (mul_out_valid) begin
			exu_result   <= mul_result;
			exu_finished <= 1'b1;
		end else if (div_out_valid) begin
			exu_result   <= div_result;
			exu_finished <= 1'b1;
		end else if (alu_done) begin
			exu_result   <= branch ? {{(exu_pkg::data_width-1){1'b0}}, branch_taken} : alu_out;
			exu_finished <= 1'b1;
		end else if (ex_to_wb) begin
			exu_finished <= 1'b0;
		end
	end

endmodule

// File: testbench/tb_exu.sv
module tb_exu;

	localparam int max_ops    = 64;
	localparam int iter_steps = 32;

	logic        clock = 1'b0;
	logic        reset;
	logic [31:0] pc;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm;
	logic        branch;
	logic [3:0]  alu_opt;
	logic        alu_mul;
	logic        alu_div;
	logic [1:0]  src_sel;
	logic [2:0]  funct3;
	logic        id_to_ex;
	logic        ex_to_wb;
	logic [31:0] exu_result;
	logic        zero_flag;
	logic        exu_finished;
	logic        exu_stall;

	// One entry per golden line with all fields kept at 32 bits
	logic [31:0] g_pc [max_ops];
	logic [31:0] g_src1 [max_ops];
	logic [31:0] g_src2 [max_ops];
	logic [31:0] g_imm [max_ops];
	logic [31:0] g_branch [max_ops];
	logic [31:0] g_opt [max_ops];
	logic [31:0] g_mul [max_ops];
	logic [31:0] g_div [max_ops];
	logic [31:0] g_sel [max_ops];
	logic [31:0] g_f3 [max_ops];
	logic [31:0] g_result [max_ops];
	logic [31:0] g_zero [max_ops];

	int num_ops;
	int current_op;
	int errors;
	int checks;
	int cycles = 0;
	int cycle_limit = 0;

	exu dut (
		.clock        (clock),
		.reset        (reset),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.branch       (branch),
		.alu_opt      (alu_opt),
		.alu_mul      (alu_mul),
		.alu_div      (alu_div),
		.src_sel      (src_sel),
		.funct3       (funct3),
		.id_to_ex     (id_to_ex),
		.ex_to_wb     (ex_to_wb),
		.exu_result   (exu_result),
		.zero_flag    (zero_flag),
		.exu_finished (exu_finished),
		.exu_stall    (exu_stall)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not complete within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at time %0t: %s = 0x%h, expected 0x%h (operation %0d)",
				$time, name, actual, expected, current_op);
		end
	endtask

	task automatic load_vectors();
		int fd;
		int fields;
		string line;
		logic [31:0] t_pc;
		logic [31:0] t_src1;
		logic [31:0] t_src2;
		logic [31:0] t_imm;
		logic [31:0] t_br;
		logic [31:0] t_opt;
		logic [31:0] t_mul;
		logic [31:0] t_div;
		logic [31:0] t_sel;
		logic [31:0] t_f3;
		logic [31:0] t_res;
		logic [31:0] t_zero;
		num_ops = 0;
		fd = $fopen("testbench/exu_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/exu_golden.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// Comment lines start with a hash
			if (line.len() < 8 || line.getc(0) == "#") begin
				continue;
			end
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
				t_pc, t_src1, t_src2, t_imm, t_br, t_opt,
				t_mul, t_div, t_sel, t_f3, t_res, t_zero);
			if (fields != 12 || num_ops >= max_ops) begin
				$display("Golden line could not be used: %s", line);
				errors++;
				continue;
			end
			g_pc[num_ops]     = t_pc;
			g_src1[num_ops]   = t_src1;
			g_src2[num_ops]   = t_src2;
			g_imm[num_ops]    = t_imm;
			g_branch[num_ops] = t_br;
			g_opt[num_ops]    = t_opt;
			g_mul[num_ops]    = t_mul;
			g_div[num_ops]    = t_div;
			g_sel[num_ops]    = t_sel;
			g_f3[num_ops]     = t_f3;
			g_result[num_ops] = t_res;
			g_zero[num_ops]   = t_zero;
			num_ops++;
		end
		$fclose(fd);
		if (num_ops == 0) begin
			$display("The golden file holds no operations");
			errors++;
		end
	endtask

	task automatic execute_line(input int n);
		int edges;
		int stall_high;
		int hold;
		logic iter;
		current_op = n;
		iter = g_mul[n][0] | g_div[n][0];
		// Withhold writeback for 0, 2 or 4 cycles
		hold = (n % 3) * 2;
		@(posedge clock);
		#2;
		pc       = g_pc[n];
		src1     = g_src1[n];
		src2     = g_src2[n];
		imm      = g_imm[n];
		branch   = g_branch[n][0];
		alu_opt  = g_opt[n][3:0];
		alu_mul  = g_mul[n][0];
		alu_div  = g_div[n][0];
		src_sel  = g_sel[n][1:0];
		funct3   = g_f3[n][2:0];
		id_to_ex = 1'b1;
		stall_high = 0;
		@(negedge clock);
		if (exu_stall) begin
			stall_high++;
		end
		@(posedge clock);
		#2;
		id_to_ex = 1'b0;
		edges = 1;
		while (!exu_finished) begin
			@(negedge clock);
			if (exu_stall) begin
				stall_high++;
			end
			@(posedge clock);
			#2;
			edges++;
		end
		// Iterative units accept on the first edge and then take iter_steps plus 2
		compare("finish latency", edges, iter ? iter_steps + 3 : 2);
		compare("exu_stall high cycles", stall_high, iter ? iter_steps + 2 : 0);
		compare("exu_stall", 32'(exu_stall), 32'd0);
		compare("exu_result", exu_result, g_result[n]);
		compare("zero_flag", 32'(zero_flag), g_zero[n]);
		repeat (hold) begin
			@(posedge clock);
			#2;
			compare("exu_finished", 32'(exu_finished), 32'd1);
			compare("exu_result", exu_result, g_result[n]);
		end
		ex_to_wb = 1'b1;
		@(posedge clock);
		#2;
		ex_to_wb = 1'b0;
		compare("exu_finished", 32'(exu_finished), 32'd0);
	endtask

	initial begin
		reset      = 1'b1;
		pc         = '0;
		src1       = '0;
		src2       = '0;
		imm        = '0;
		branch     = 1'b0;
		alu_opt    = '0;
		alu_mul    = 1'b0;
		alu_div    = 1'b0;
		src_sel    = '0;
		funct3     = '0;
		id_to_ex   = 1'b0;
		ex_to_wb   = 1'b0;
		errors     = 0;
		checks     = 0;
		current_op = -1;
		load_vectors();
		cycle_limit = num_ops * 40 + 100;
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		compare("exu_finished", 32'(exu_finished), 32'd0);
		compare("exu_stall", 32'(exu_stall), 32'd0);
		compare("exu_result", exu_result, 32'd0);
		for (int i = 0; i < num_ops; i++) begin
			execute_line(i);
		end
		$display("Operations: %0d, checks: %0d, errors: %0d", num_ops, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: testbench/exu_golden.txt
# pc       src1     src2     imm      br op mu dv sl f3 result   z   (all fields hex)
# op = alu_opt, mu/dv = alu_mul/alu_div, sl = src_sel, z = expected zero_flag
00001000 00000005 00000007 00000000 0 0 0 0 0 0 0000000c 0
00001000 00000010 00000010 00000000 0 1 0 0 0 0 00000000 1
00001000 00000003 00000000 00000024 0 2 0 0 1 0 00000030 0
00001000 ffffffff 00000001 00000000 0 3 0 0 0 0 00000001 0
00001000 ffffffff 00000001 00000000 0 4 0 0 0 0 00000000 1
00001000 0f0f0f0f 00000000 ffff0000 0 5 0 0 1 0 f0f00f0f 0
00001000 80000000 00000004 00000000 0 6 0 0 0 0 08000000 0
00001000 80000000 00000004 00000000 0 7 0 0 0 0 f8000000 0
00001000 12340000 00005678 00000000 0 8 0 0 0 0 12345678 0
00001000 f0f0f0f0 3c3c3c3c 00000000 0 9 0 0 0 0 30303030 0
00001000 00000000 00000000 00000000 0 0 0 0 2 0 00001004 0
00001000 00000000 00000000 fffffff0 0 0 0 0 3 0 00000ff0 0
00002000 0000002a 0000002a 00000000 1 1 0 0 0 0 00000001 0
00002000 0000002a 0000002a 00000000 1 1 0 0 0 1 00000000 1
00002000 fffffffe 00000003 00000000 1 3 0 0 0 4 00000001 0
00002000 fffffffe 00000003 00000000 1 3 0 0 0 5 00000000 1
00002000 fffffffe 00000003 00000000 1 4 0 0 0 6 00000000 1
00002000 fffffffe 00000003 00000000 1 4 0 0 0 7 00000001 0
00003000 00000007 fffffffd 00000000 0 0 1 0 0 0 ffffffeb 0
00003000 80000000 80000000 00000000 0 0 1 0 0 1 40000000 0
00003000 ffffffff ffffffff 00000000 0 0 1 0 0 2 ffffffff 0
00003000 ffffffff ffffffff 00000000 0 0 1 0 0 3 fffffffe 0
00004000 ffffffec 00000006 00000000 0 0 0 1 0 4 fffffffd 0
00004000 ffffffec 00000006 00000000 0 0 0 1 0 5 2aaaaaa7 0
00004000 ffffffec 00000006 00000000 0 0 0 1 0 6 fffffffe 0
00004000 ffffffec 00000006 00000000 0 0 0 1 0 7 00000002 0
00004000 00000064 00000000 00000000 0 0 0 1 0 4 ffffffff 0
00004000 fffffff9 00000000 00000000 0 0 0 1 0 6 fffffff9 0
00004000 80000000 ffffffff 00000000 0 0 0 1 0 4 80000000 0
00004000 80000000 ffffffff 00000000 0 0 0 1 0 6 00000000 1

// File: build.f
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_mul.sv
verilog/exu_div.sv
verilog/exu.sv
testbench/tb_exu.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench and scan its log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module tb_exu -o tb_exu_sim &&
	./obj_dir/tb_exu_sim > sim.log 2>&1 ||
	{ echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
